// File: rtl/frame_fifo_pkg.sv
/* frame fifo shared definitions */

package frame_fifo_pkg;

    // memory address bits, pointers carry one extra wrap bit
    localparam int addr_width = 4;
    localparam int data_width = 8;
    localparam int fifo_depth = 1 << addr_width;

    // keep accepting while full and drop the frame
    localparam bit drop_when_full = 1'b1;

    // write side frame handling
    typedef enum logic {
        st_pass = 1'b0,
        st_drop = 1'b1
    } write_state_t;

endpackage

// File: rtl/reset_sync.sv
/* dual domain reset synchronizer */
`timescale 1ns/1ns

module reset_sync (
    input  logic input_clk,
    input  logic output_clk,
    input  logic async_rst,
    output logic in_rst,
    output logic out_rst
);

    logic [2:0] in_chain;
    logic [2:0] out_chain;

    // write side also held until the read side starts leaving reset
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_chain <= 3'b111;
        end else begin
            in_chain <= {in_chain[1], in_chain[0] | out_chain[0], 1'b0};
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_chain <= 3'b111;
        end else begin
            out_chain <= {out_chain[1:0], 1'b0};
        end
    end

    assign in_rst = in_chain[2];
    assign out_rst = out_chain[2];

endmodule

// File: rtl/gray_ptr_counter.sv
/* gray pointer counter */
`timescale 1ns/1ns

module gray_ptr_counter
    import frame_fifo_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  logic                load,
    input  logic [addr_width:0] load_value,
    output logic [addr_width:0] ptr,
    output logic [addr_width:0] ptr_gray
);

    logic [addr_width:0] ptr_next;

    // load wins over advance
    always_comb begin
        ptr_next = ptr;
        if (load) begin
            ptr_next = load_value;
        end else if (advance) begin
            ptr_next = ptr + 1'b1;
        end
    end

    // gray copy is registered from the same next value,
    // so both outputs change on the same edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
            ptr_gray <= '0;
        end else begin
            ptr <= ptr_next;
            ptr_gray <= ptr_next ^ (ptr_next >> 1);
        end
    end

endmodule

// File: rtl/frame_write_ctrl.sv
/* write side frame controller */
`timescale 1ns/1ns

module frame_write_ctrl
    import frame_fifo_pkg::*;
(
    input  logic                  input_clk,
    input  logic                  in_rst,
    input  logic [data_width-1:0] in_data,
    input  logic                  in_valid,
    input  logic                  in_last,
    input  logic                  in_user,
    input  logic [addr_width:0]   wr_ptr,
    input  logic [addr_width:0]   rd_ptr_gray,
    output logic                  in_ready,
    output logic                  mem_we,
    output logic [addr_width-1:0] mem_waddr,
    output logic [data_width:0]   mem_wdata,
    output logic                  commit,
    output logic [addr_width:0]   commit_ptr,
    output logic                  good_pulse,
    output logic                  bad_pulse,
    output logic                  overflow_pulse
);

    write_state_t        state;
    logic [addr_width:0] cur_ptr;
    logic [addr_width:0] cur_gray;
    logic [addr_width:0] rd_gray_sync1;
    logic [addr_width:0] rd_gray_sync2;
    logic                run;
    logic                full;
    logic                frame_full;
    logic                accept;

    assign cur_gray = cur_ptr ^ (cur_ptr >> 1);

    // full when the top two gray bits differ and the rest match
    assign full = cur_gray == {~rd_gray_sync2[addr_width:addr_width-1],
                               rd_gray_sync2[addr_width-2:0]};
    // frame alone already fills the memory
    assign frame_full = (cur_ptr - wr_ptr) == (addr_width + 1)'(fifo_depth);

    assign in_ready = run && (!full || frame_full || drop_when_full);
    assign accept = in_valid && in_ready;

    assign mem_we = accept && state == st_pass && !full && !frame_full;
    assign mem_waddr = cur_ptr[addr_width-1:0];
    assign mem_wdata = {in_last, in_data};
    assign commit = mem_we && in_last && !in_user;
    assign commit_ptr = cur_ptr + 1'b1;

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            run <= 1'b0;
            state <= st_pass;
            cur_ptr <= '0;
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
            good_pulse <= 1'b0;
            bad_pulse <= 1'b0;
            overflow_pulse <= 1'b0;
        end else begin
            run <= 1'b1;
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
            good_pulse <= commit;
            bad_pulse <= mem_we && in_last && in_user;
            overflow_pulse <= 1'b0;
            if (accept) begin
                case (state)
                    st_pass: begin
                        if (!mem_we) begin
                            // no room, give up on the whole frame
                            if (in_last) begin
                                cur_ptr <= wr_ptr;
                                overflow_pulse <= 1'b1;
                            end else begin
                                state <= st_drop;
                            end
                        end else if (in_last && in_user) begin
                            cur_ptr <= wr_ptr;
                        end else begin
                            cur_ptr <= commit_ptr;
                        end
                    end
                    st_drop: begin
                        if (in_last) begin
                            cur_ptr <= wr_ptr;
                            overflow_pulse <= 1'b1;
                            state <= st_pass;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/frame_memory.sv
/* dual clock frame memory */
`timescale 1ns/1ns

module frame_memory
    import frame_fifo_pkg::*;
(
    input  logic                  input_clk,
    input  logic                  output_clk,
    input  logic                  mem_we,
    input  logic                  mem_re,
    input  logic [addr_width-1:0] mem_waddr,
    input  logic [addr_width-1:0] mem_raddr,
    input  logic [data_width:0]   mem_wdata,
    output logic [data_width:0]   mem_rdata
);

    // each entry is last flag plus data byte
    logic [data_width:0] mem [fifo_depth];

    always_ff @(posedge input_clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // read data held until the next pop
    always_ff @(posedge output_clk) begin
        if (mem_re) begin
            mem_rdata <= mem[mem_raddr];
        end
    end

endmodule

// File: rtl/frame_read_stage.sv
/* read side output stage */
`timescale 1ns/1ns

module frame_read_stage
    import frame_fifo_pkg::*;
(
    input  logic                  output_clk,
    input  logic                  out_rst,
    input  logic                  out_ready,
    input  logic [addr_width:0]   wr_ptr_gray,
    input  logic [addr_width:0]   rd_ptr,
    input  logic [addr_width:0]   rd_ptr_gray,
    input  logic [data_width:0]   mem_rdata,
    output logic                  out_valid,
    output logic [data_width-1:0] out_data,
    output logic                  out_last,
    output logic                  rd_advance,
    output logic                  mem_re,
    output logic [addr_width-1:0] mem_raddr
);

    logic [addr_width:0] wr_gray_sync1;
    logic [addr_width:0] wr_gray_sync2;
    logic                empty;
    logic                pop;

    // only committed frames are visible here
    assign empty = rd_ptr_gray == wr_gray_sync2;

    // refill when the output register is free or being taken
    assign pop = (out_ready || !out_valid) && !empty;

    assign rd_advance = pop;
    assign mem_re = pop;
    assign mem_raddr = rd_ptr[addr_width-1:0];
    assign {out_last, out_data} = mem_rdata;

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
            out_valid <= 1'b0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
            if (out_ready || !out_valid) begin
                out_valid <= !empty;
            end
        end
    end

endmodule

// File: rtl/status_pulse_sync.sv
/* status pulse synchronizer */
`timescale 1ns/1ns

module status_pulse_sync (
    input  logic input_clk,
    input  logic output_clk,
    input  logic in_rst,
    input  logic out_rst,
    input  logic good_pulse,
    input  logic bad_pulse,
    input  logic overflow_pulse,
    output logic out_good,
    output logic out_bad,
    output logic out_overflow
);

    // bit order overflow, bad, good
    logic [2:0] toggle;
    logic [2:0] sync1;
    logic [2:0] sync2;
    logic [2:0] sync3;

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            toggle <= '0;
        end else begin
            toggle <= toggle ^ {overflow_pulse, bad_pulse, good_pulse};
        end
    end

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            sync1 <= '0;
            sync2 <= '0;
            sync3 <= '0;
        end else begin
            sync1 <= toggle;
            sync2 <= sync1;
            sync3 <= sync2;
        end
    end

    // one cycle pulse per toggle edge
    assign {out_overflow, out_bad, out_good} = sync2 ^ sync3;

endmodule

// File: rtl/async_frame_fifo.sv
/* async frame fifo top */
`timescale 1ns/1ns

module async_frame_fifo
    import frame_fifo_pkg::*;
(
    input  logic                  input_clk,
    input  logic                  output_clk,
    input  logic                  async_rst,
    input  logic [data_width-1:0] in_data,
    input  logic                  in_valid,
    input  logic                  in_last,
    input  logic                  in_user,
    output logic                  in_ready,
    output logic [data_width-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  out_last,
    output logic                  in_good,
    output logic                  in_bad,
    output logic                  in_overflow,
    output logic                  out_good,
    output logic                  out_bad,
    output logic                  out_overflow
);

    logic                  in_rst;
    logic                  out_rst;
    logic [addr_width:0]   wr_ptr;
    logic [addr_width:0]   wr_ptr_gray;
    logic [addr_width:0]   rd_ptr;
    logic [addr_width:0]   rd_ptr_gray;
    logic [addr_width:0]   commit_ptr;
    logic                  commit;
    logic                  rd_advance;
    logic                  mem_we;
    logic                  mem_re;
    logic [addr_width-1:0] mem_waddr;
    logic [addr_width-1:0] mem_raddr;
    logic [data_width:0]   mem_wdata;
    logic [data_width:0]   mem_rdata;

    reset_sync reset_sync_i (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .in_rst     (in_rst),
        .out_rst    (out_rst)
    );

    frame_write_ctrl frame_write_ctrl_i (
        .input_clk      (input_clk),
        .in_rst         (in_rst),
        .in_data        (in_data),
        .in_valid       (in_valid),
        .in_last        (in_last),
        .in_user        (in_user),
        .wr_ptr         (wr_ptr),
        .rd_ptr_gray    (rd_ptr_gray),
        .in_ready       (in_ready),
        .mem_we         (mem_we),
        .mem_waddr      (mem_waddr),
        .mem_wdata      (mem_wdata),
        .commit         (commit),
        .commit_ptr     (commit_ptr),
        .good_pulse     (in_good),
        .bad_pulse      (in_bad),
        .overflow_pulse (in_overflow)
    );

    // committed write pointer, only moves on a good frame end
    gray_ptr_counter wr_ptr_counter_i (
        .clk        (input_clk),
        .rst        (in_rst),
        .advance    (1'b0),
        .load       (commit),
        .load_value (commit_ptr),
        .ptr        (wr_ptr),
        .ptr_gray   (wr_ptr_gray)
    );

    gray_ptr_counter rd_ptr_counter_i (
        .clk        (output_clk),
        .rst        (out_rst),
        .advance    (rd_advance),
        .load       (1'b0),
        .load_value ('0),
        .ptr        (rd_ptr),
        .ptr_gray   (rd_ptr_gray)
    );

    frame_memory frame_memory_i (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .mem_waddr  (mem_waddr),
        .mem_raddr  (mem_raddr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    frame_read_stage frame_read_stage_i (
        .output_clk  (output_clk),
        .out_rst     (out_rst),
        .out_ready   (out_ready),
        .wr_ptr_gray (wr_ptr_gray),
        .rd_ptr      (rd_ptr),
        .rd_ptr_gray (rd_ptr_gray),
        .mem_rdata   (mem_rdata),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .rd_advance  (rd_advance),
        .mem_re      (mem_re),
        .mem_raddr   (mem_raddr)
    );

    status_pulse_sync status_pulse_sync_i (
        .input_clk      (input_clk),
        .output_clk     (output_clk),
        .in_rst         (in_rst),
        .out_rst        (out_rst),
        .good_pulse     (in_good),
        .bad_pulse      (in_bad),
        .overflow_pulse (in_overflow),
        .out_good       (out_good),
        .out_bad        (out_bad),
        .out_overflow   (out_overflow)
    );

endmodule

// File: sim/tb_clock_gen.sv
/* test clocks and reset */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic input_clk,
    output logic output_clk,
    output logic async_rst
);

    // 40 ns write clock
    initial begin
        input_clk = 1'b0;
        forever #20 input_clk = ~input_clk;
    end

    // 56 ns read clock
    initial begin
        output_clk = 1'b0;
        forever #28 output_clk = ~output_clk;
    end

    // held over four write clock cycles
    initial begin
        async_rst = 1'b1;
        repeat (4) @(posedge input_clk);
        #2;
        async_rst = 1'b0;
    end

endmodule

// File: sim/async_frame_fifo_sva.sv
/* frame fifo assertions */
`timescale 1ns/1ns

module async_frame_fifo_sva
    import frame_fifo_pkg::*;
(
    input logic                  input_clk,
    input logic                  output_clk,
    input logic                  in_rst,
    input logic                  out_rst,
    input logic                  in_ready,
    input logic                  in_good,
    input logic                  in_bad,
    input logic                  in_overflow,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic                  out_last,
    input logic [data_width-1:0] out_data
);

    int failures = 0;

    // output word held under back-pressure
    out_hold: assert property (@(posedge output_clk) disable iff (out_rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            $error("output word changed while out_ready was low");
            failures++;
        end

    // input never stalls while frames are dropped when full
    ready_held: assert property (@(posedge input_clk) disable iff (in_rst)
        drop_when_full && in_ready |=> in_ready)
        else begin
            $error("in_ready dropped although full frames are dropped");
            failures++;
        end

    one_status: assert property (@(posedge input_clk) disable iff (in_rst)
        $onehot0({in_good, in_bad, in_overflow}))
        else begin
            $error("two input status pulses in the same cycle");
            failures++;
        end

endmodule

bind async_frame_fifo async_frame_fifo_sva async_frame_fifo_sva_i (
    .input_clk   (input_clk),
    .output_clk  (output_clk),
    .in_rst      (in_rst),
    .out_rst     (out_rst),
    .in_ready    (in_ready),
    .in_good     (in_good),
    .in_bad      (in_bad),
    .in_overflow (in_overflow),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_last    (out_last),
    .out_data    (out_data)
);

// File: sim/async_frame_fifo_tb.sv
/* async frame fifo testbench */
`timescale 1ns/1ns

module async_frame_fifo_tb
    import frame_fifo_pkg::*;
();

    // all tests need roughly 1000 input cycles
    localparam int timeout_cycles = 4000;

    localparam int outcome_good = 0;
    localparam int outcome_bad = 1;
    localparam int outcome_overflow = 2;

    logic                  input_clk;
    logic                  output_clk;
    logic                  async_rst;
    logic [data_width-1:0] in_data;
    logic                  in_valid;
    logic                  in_last;
    logic                  in_user;
    logic                  in_ready;
    logic [data_width-1:0] out_data;
    logic                  out_valid;
    logic                  out_ready;
    logic                  out_last;
    logic                  in_good;
    logic                  in_bad;
    logic                  in_overflow;
    logic                  out_good;
    logic                  out_bad;
    logic                  out_overflow;

    // expected output words, last flag on top
    logic [data_width:0] expected_words [$];
    string               test_name = "reset";
    logic [31:0]         stim_seed = 32'hab95;
    logic [31:0]         ready_seed = 32'hab95;
    bit                  ready_hold = 1'b0;
    bit                  ready_random = 1'b0;
    int                  cycle_count = 0;
    int                  exp_good = 0;
    int                  exp_bad = 0;
    int                  exp_overflow = 0;
    int                  in_good_count = 0;
    int                  in_bad_count = 0;
    int                  in_overflow_count = 0;
    int                  out_good_count = 0;
    int                  out_bad_count = 0;
    int                  out_overflow_count = 0;

    tb_clock_gen tb_clock_gen_i (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .async_rst  (async_rst)
    );

    async_frame_fifo async_frame_fifo_i (
        .input_clk    (input_clk),
        .output_clk   (output_clk),
        .async_rst    (async_rst),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_user      (in_user),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .in_good      (in_good),
        .in_bad       (in_bad),
        .in_overflow  (in_overflow),
        .out_good     (out_good),
        .out_bad      (out_bad),
        .out_overflow (out_overflow)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int random_length(input int max_len);
        stim_seed = lcg_next(stim_seed);
        return 1 + int'(stim_seed[23:16]) % max_len;
    endfunction

    // reference model: a frame must fit beside the stored words,
    // and only a fitting frame is judged by its user flag
    function automatic int frame_outcome(input int len, input bit user_bad,
                                         input int occupancy);
        if (len > fifo_depth - occupancy) begin
            return outcome_overflow;
        end
        if (user_bad) begin
            return outcome_bad;
        end
        return outcome_good;
    endfunction

    task automatic check_word(input logic [data_width:0] expected,
                              input logic [data_width:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "output word mismatch");
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what,
                     expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "status count mismatch");
        end
    endtask

    // every stimulus task starts and ends 2 ns after an input edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge input_clk);
        #2;
    endtask

    task automatic send_frame(input int len, input bit user_bad, input int occupancy);
        logic [data_width-1:0] frame_bytes [$];
        int                    outcome;
        int                    i;
        bit                    accepted;
        outcome = frame_outcome(len, user_bad, occupancy);
        for (i = 0; i < len; i++) begin
            stim_seed = lcg_next(stim_seed);
            frame_bytes.push_back(stim_seed[23:16]);
        end
        case (outcome)
            outcome_good: begin
                exp_good++;
                for (i = 0; i < len; i++) begin
                    expected_words.push_back({i == len - 1, frame_bytes[i]});
                end
            end
            outcome_bad: exp_bad++;
            default: exp_overflow++;
        endcase
        for (i = 0; i < len; i++) begin
            in_data = frame_bytes[i];
            in_valid = 1'b1;
            in_last = (i == len - 1);
            in_user = user_bad && (i == len - 1);
            accepted = 1'b0;
            // in_ready is settled here and holds until the next edge
            while (!accepted) begin
                accepted = in_ready;
                wait_cycles(1);
            end
        end
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
    endtask

    task automatic drain_and_check();
        do begin
            wait_cycles(1);
        end while (expected_words.size() != 0);
        // status pulses still crossing
        wait_cycles(12);
        check_count("in_good", exp_good, in_good_count);
        check_count("in_bad", exp_bad, in_bad_count);
        check_count("in_overflow", exp_overflow, in_overflow_count);
        check_count("out_good", exp_good, out_good_count);
        check_count("out_bad", exp_bad, out_bad_count);
        check_count("out_overflow", exp_overflow, out_overflow_count);
    endtask

    always @(posedge input_clk) begin
        in_good_count += in_good;
        in_bad_count += in_bad;
        in_overflow_count += in_overflow;
    end

    always @(posedge output_clk) begin
        out_good_count += out_good;
        out_bad_count += out_bad;
        out_overflow_count += out_overflow;
    end

    // compare each output transfer with the reference queue
    always @(posedge output_clk) begin
        if (out_valid && out_ready) begin
            if (expected_words.size() == 0) begin
                $display("output word %h arrived in %s with no frame expected",
                         {out_last, out_data}, test_name);
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected output word");
            end else begin
                check_word(expected_words.pop_front(), {out_last, out_data});
            end
        end
    end

    // read back-pressure, mode taken at the edge and driven 2 ns later
    always @(posedge output_clk) begin
        logic next_ready;
        next_ready = 1'b1;
        if (ready_hold) begin
            next_ready = 1'b0;
        end else if (ready_random) begin
            ready_seed = lcg_next(ready_seed);
            next_ready = ready_seed[17:16] != 2'b00;
        end
        #2;
        out_ready = next_ready;
    end

    always @(posedge input_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("run stopped: no finish after %0d input cycles", timeout_cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int f;
        int len_a;
        in_data = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
        out_ready = 1'b0;
        wait (async_rst === 1'b0);
        wait_cycles(10);

        test_name = "good_frames";
        for (f = 0; f < 8; f++) begin
            send_frame(random_length(12), 1'b0, 0);
            drain_and_check();
        end

        test_name = "bad_frame";
        send_frame(random_length(12), 1'b1, 0);
        drain_and_check();
        send_frame(random_length(12), 1'b0, 0);
        drain_and_check();

        test_name = "long_frame";
        send_frame(20, 1'b0, 0);
        drain_and_check();
        send_frame(random_length(12), 1'b0, 0);
        drain_and_check();
        send_frame(random_length(12), 1'b0, 0);
        drain_and_check();

        // frame pairs never exceed the memory together
        test_name = "ready_gaps";
        ready_random = 1'b1;
        for (f = 0; f < 5; f++) begin
            len_a = random_length(8);
            send_frame(len_a, 1'b0, 0);
            wait_cycles(8);
            send_frame(random_length(8), 1'b0, len_a);
            drain_and_check();
        end
        ready_random = 1'b0;

        test_name = "full_drop";
        ready_hold = 1'b1;
        wait_cycles(4);
        send_frame(10, 1'b0, 0);
        wait_cycles(100);
        // one word already sits in the output register
        send_frame(10, 1'b0, 9);
        wait_cycles(8);
        ready_hold = 1'b0;
        drain_and_check();

        if (async_frame_fifo_i.async_frame_fifo_sva_i.failures == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures",
                     async_frame_fifo_i.async_frame_fifo_sva_i.failures);
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: compile.f
rtl/frame_fifo_pkg.sv
rtl/reset_sync.sv
rtl/gray_ptr_counter.sv
rtl/frame_write_ctrl.sv
rtl/frame_memory.sv
rtl/frame_read_stage.sv
rtl/status_pulse_sync.sv
rtl/async_frame_fifo.sv
sim/tb_clock_gen.sv
sim/async_frame_fifo_sva.sv
sim/async_frame_fifo_tb.sv

// File: Bender.yml
package:
  name: async_frame_fifo

sources:
  - rtl/frame_fifo_pkg.sv
  - rtl/reset_sync.sv
  - rtl/gray_ptr_counter.sv
  - rtl/frame_write_ctrl.sv
  - rtl/frame_memory.sv
  - rtl/frame_read_stage.sv
  - rtl/status_pulse_sync.sv
  - rtl/async_frame_fifo.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/async_frame_fifo_sva.sv
      - sim/async_frame_fifo_tb.sv
